// ==== Makefile ====
# Verilator simulation of the Z180 glue logic testbench

TOP = z180_glue_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f tb.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== tb.f ====
verilog/z180_glue_pkg.sv
verilog/boot_rom.sv
verilog/bus_sampler.sv
verilog/addr_decode.sv
verilog/bus_responder.sv
verilog/board_control.sv
verilog/z180_glue_top.sv
tb/z180_glue_sva.sv
tb/z180_glue_tb.sv

// ==== tb/z180_glue_sva.sv ====
/*
 * Bus-drive assertions for the bus responder
 *   Data bus against SRAM, read against write strobe, idle in reset
 *   Bound into every bus_responder instance
 */
`timescale 1ns/1ps

module z180_glue_sva (
    input logic hwclk,
    input logic rst,
    input logic d_oe,
    input logic ce_n,
    input logic oe_n,
    input logic we_n
);

    // ******************************
    // Drive exclusivity
    // ******************************
    // FPGA and SRAM never share the data bus
    a_data_vs_sram: assert property (
        @(posedge hwclk) disable iff (rst) !(d_oe && !ce_n)
    ) else $error("d_oe high while ce_n is low");

    a_oe_we: assert property (
        @(posedge hwclk) disable iff (rst) !(!oe_n && !we_n)   // SRAM read or write
    ) else $error("oe_n and we_n low together");

    // Bus released one cycle into reset
    a_reset_idle: assert property (
        @(posedge hwclk) rst |=> (!d_oe && ce_n)
    ) else $error("bus outputs active after reset");

endmodule

bind bus_responder z180_glue_sva u_sva (
    .hwclk(hwclk), .rst(rst), .d_oe(d_oe), .ce_n(ce_n), .oe_n(oe_n), .we_n(we_n)
);

// ==== tb/z180_glue_tb.sv ====
/*
 * Testbench for the Z180 board glue logic
 *   CPU bus model with response and release timeouts
 *   Stimulus table, random boot ROM reads, compare tasks
 *   CPU clock and push-button reset checks
 */
`timescale 1ns/1ps

module z180_glue_tb;

    localparam int         ROM_BYTES  = 512;
    localparam logic [7:0] LED_PORT   = 8'h40;
    localparam int         RESET_HOLD = 12;     // Shorter than default, passed down
    localparam int         RESP_WAIT  = 12;     // Response is due 5 edges into an access
    localparam int         N_RANDOM   = 20;

    typedef struct packed {
        logic mreq_n;
        logic iorq_n;
        logic rd_n;
        logic wr_n;
        logic m1_n;
    } cpu_pins_t;

    typedef struct packed {
        logic ce_n;
        logic oe_n;
        logic we_n;
    } sram_ctl_t;

    // One table row: the access and what should answer it
    typedef struct packed {
        z180_glue_pkg::access_op_e op;
        z180_glue_pkg::addr_t      addr;
        z180_glue_pkg::data_t      wdata;
        z180_glue_pkg::region_e    exp_region;  // REG_NONE when nothing answers
        z180_glue_pkg::data_t      exp_data;    // LED read-back, ROM rows use the image
    } stim_t;

    localparam cpu_pins_t PINS_IDLE = '1;
    localparam sram_ctl_t SRAM_IDLE = '1;

    logic                   hwclk;
    logic                   rst;
    logic                   s1_n;
    z180_glue_pkg::addr_t   a;
    z180_glue_pkg::data_t   d_in;
    cpu_pins_t              pins;           // CPU strobes as driven
    z180_glue_pkg::data_t   d_out;
    logic                   d_oe, ce_n, oe_n, we_n;
    logic [7:0]             led;
    logic                   extal, reset_n;
    logic                   busreq_n, dreq1_n, nmi_n, wait_n;
    logic [2:0]             int_n;

    z180_glue_pkg::data_t   rom_img [0:511];    // Expected ROM bytes
    z180_glue_pkg::data_t   led_model;          // Last byte written to the LED port
    stim_t                  stim_q[$];
    integer                 seed = 32'h4021_b48c;
    int unsigned            rnd;

    z180_glue_top #(
        .ROM_BYTES(ROM_BYTES), .LED_PORT(LED_PORT), .RESET_HOLD(RESET_HOLD)
    ) uut (
        .hwclk, .rst, .s1_n, .a,
        .mreq_n(pins.mreq_n), .iorq_n(pins.iorq_n), .rd_n(pins.rd_n),
        .wr_n(pins.wr_n), .m1_n(pins.m1_n),
        .d_in, .d_out, .d_oe, .ce_n, .oe_n, .we_n, .led, .extal, .reset_n,
        .busreq_n, .dreq1_n, .int_n, .nmi_n, .wait_n
    );

    initial begin
        hwclk = 1'b0;
        forever #20 hwclk = ~hwclk;     // 40 ns period
    end

    // ******************************
    // Failure and compare tasks
    // ******************************
    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        stop_run();
    endtask

    task automatic check_data(input string name, input z180_glue_pkg::data_t got,
                              input z180_glue_pkg::data_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = 8'h%02h, expected 8'h%02h",
                     $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_led(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: led = 8'h%02h, expected 8'h%02h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_sram_ctl(input sram_ctl_t got, input sram_ctl_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: {ce_n,oe_n,we_n} = %b, expected %b",
                     $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_region(input z180_glue_pkg::region_e got,
                                input z180_glue_pkg::region_e exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: responding region = %s, expected %s",
                     $time, got.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Unused CPU requests sit at their inactive level
    task automatic check_tie_offs();
        check_level("busreq_n", busreq_n, 1'b1);
        check_level("dreq1_n", dreq1_n, 1'b1);
        check_level("nmi_n", nmi_n, 1'b1);
        check_level("wait_n", wait_n, 1'b1);
        for (int i = 0; i < 3; i++)
            check_level($sformatf("int_n[%0d]", i), int_n[i], 1'b1);
    endtask

    // ******************************
    // CPU bus model
    // ******************************
    task automatic next_cycle();
        @(posedge hwclk);
        #2;                                 // Drive and sample point
    endtask

    function automatic stim_t make_stim(input z180_glue_pkg::access_op_e op,
                                        input z180_glue_pkg::addr_t addr,
                                        input z180_glue_pkg::data_t wdata,
                                        input z180_glue_pkg::region_e exp_region,
                                        input z180_glue_pkg::data_t exp_data);
        stim_t s;
        s.op         = op;
        s.addr       = addr;
        s.wdata      = wdata;
        s.exp_region = exp_region;
        s.exp_data   = exp_data;
        return s;
    endfunction

    function automatic cpu_pins_t strobes_for(input z180_glue_pkg::access_op_e op);
        cpu_pins_t p;
        p = PINS_IDLE;
        case (op)
            z180_glue_pkg::OP_MEM_RD: begin
                p.mreq_n = 1'b0;
                p.rd_n   = 1'b0;
            end
            z180_glue_pkg::OP_MEM_WR: begin
                p.mreq_n = 1'b0;
                p.wr_n   = 1'b0;
            end
            z180_glue_pkg::OP_IO_RD: begin
                p.iorq_n = 1'b0;
                p.rd_n   = 1'b0;
            end
            z180_glue_pkg::OP_IO_WR: begin
                p.iorq_n = 1'b0;
                p.wr_n   = 1'b0;
            end
            z180_glue_pkg::OP_INTA: begin
                p.iorq_n = 1'b0;
                p.m1_n   = 1'b0;            // Interrupt acknowledge
            end
            default: p = PINS_IDLE;
        endcase
        return p;
    endfunction

    function automatic sram_ctl_t sram_pins();
        return {ce_n, oe_n, we_n};
    endfunction

    // Target as seen from the pins: SRAM strobes, driven data or an LED change
    function automatic z180_glue_pkg::region_e observed_region(
        input z180_glue_pkg::access_op_e op, input logic [7:0] led_before);
        z180_glue_pkg::region_e r;
        logic                   is_mem;
        is_mem = (op == z180_glue_pkg::OP_MEM_RD) || (op == z180_glue_pkg::OP_MEM_WR);
        if (!ce_n || !oe_n || !we_n)
            r = z180_glue_pkg::REG_SRAM;
        else if (d_oe)
            r = is_mem ? z180_glue_pkg::REG_ROM : z180_glue_pkg::REG_LED;
        else if (led !== led_before)
            r = z180_glue_pkg::REG_LED;
        else
            r = z180_glue_pkg::REG_NONE;
        return r;
    endfunction

    task automatic end_access();
        bit idle;
        idle = 1'b0;
        pins = PINS_IDLE;
        d_in = 8'h00;
        for (int i = 0; i < RESP_WAIT && !idle; i++) begin
            next_cycle();
            idle = !d_oe && ce_n && oe_n && we_n;
        end
        if (!idle)
            timeout_fail("the bus outputs to release");
        check_led(led, ~led_model);         // Register holds after the access
        repeat (3) next_cycle();            // Idle T-states between accesses
        check_level("d_oe", d_oe, 1'b0);    // Still released before the next access
        check_sram_ctl(sram_pins(), SRAM_IDLE);
    endtask

    task automatic run_access(input stim_t s);
        logic [7:0] led_before;
        sram_ctl_t  exp_ctl;
        bit         seen;
        led_before = led;
        seen       = 1'b0;
        a    = s.addr;
        d_in = s.wdata;
        pins = strobes_for(s.op);
        for (int i = 0; i < RESP_WAIT && !seen; i++) begin
            next_cycle();
            seen = d_oe || !ce_n || !oe_n || !we_n || (led !== led_before);
        end
        if (!seen && s.exp_region != z180_glue_pkg::REG_NONE)
            timeout_fail($sformatf("a response at address 20'h%05h", s.addr));
        check_region(observed_region(s.op, led_before), s.exp_region);
        case (s.exp_region)
            z180_glue_pkg::REG_ROM: begin
                check_data("d_out", d_out, rom_img[s.addr[8:0]]);
                check_sram_ctl(sram_pins(), SRAM_IDLE);
            end
            z180_glue_pkg::REG_SRAM: begin
                exp_ctl.ce_n = 1'b0;
                exp_ctl.oe_n = (s.op != z180_glue_pkg::OP_MEM_RD);
                exp_ctl.we_n = (s.op != z180_glue_pkg::OP_MEM_WR);
                check_sram_ctl(sram_pins(), exp_ctl);
                check_level("d_oe", d_oe, 1'b0);
            end
            z180_glue_pkg::REG_LED: begin
                if (s.op == z180_glue_pkg::OP_IO_WR)
                    led_model = s.wdata;    // LEDs show the inverted byte
                else
                    check_data("d_out", d_out, s.exp_data);
                check_led(led, ~led_model);
            end
            default: begin
                check_level("d_oe", d_oe, 1'b0);
                check_sram_ctl(sram_pins(), SRAM_IDLE);
                check_led(led, led_before);
            end
        endcase
        end_access();
    endtask

    task automatic wait_reset_high(input string what);
        int cnt;
        for (cnt = 0; cnt < RESET_HOLD + 4 && !reset_n; cnt++)
            next_cycle();
        if (!reset_n)
            timeout_fail(what);
        if (cnt < RESET_HOLD) begin
            $display("reset_n rose after %0d cycles, before the hold time ran out", cnt);
            stop_run();
        end
    endtask

    // ******************************
    // Clock and push-button reset
    // ******************************
    task automatic check_board();
        logic prev;
        int   cnt;
        prev = extal;
        repeat (8) begin
            next_cycle();
            check_level("extal", extal, ~prev);
            prev = extal;
        end
        s1_n = 1'b0;                        // Button pressed
        for (cnt = 0; cnt < 8 && reset_n; cnt++)
            next_cycle();
        if (reset_n)
            timeout_fail("reset_n to fall while s1_n is low");
        repeat (4) next_cycle();
        s1_n = 1'b1;
        wait_reset_high("reset_n to rise after s1_n release");
    endtask

    // ******************************
    // Stimulus
    // ******************************
    initial begin
        rst       = 1'b1;
        s1_n      = 1'b1;
        a         = '0;
        d_in      = '0;
        pins      = PINS_IDLE;
        led_model = '0;
        $readmemh("verilog/boot_rom.hex", rom_img);

        stim_q.push_back(make_stim(z180_glue_pkg::OP_MEM_RD, 20'h00000, 8'h00,
                                   z180_glue_pkg::REG_ROM, 8'h00));
        stim_q.push_back(make_stim(z180_glue_pkg::OP_MEM_RD, 20'h001FF, 8'h00,
                                   z180_glue_pkg::REG_ROM, 8'h00));    // Last ROM byte
        stim_q.push_back(make_stim(z180_glue_pkg::OP_MEM_RD, 20'h00200, 8'h00,
                                   z180_glue_pkg::REG_SRAM, 8'h00));   // First SRAM byte
        stim_q.push_back(make_stim(z180_glue_pkg::OP_MEM_WR, 20'h3ABCD, 8'h5A,
                                   z180_glue_pkg::REG_SRAM, 8'h00));
        stim_q.push_back(make_stim(z180_glue_pkg::OP_MEM_WR, 20'h00010, 8'hA5,
                                   z180_glue_pkg::REG_NONE, 8'h00));   // ROM write ignored
        stim_q.push_back(make_stim(z180_glue_pkg::OP_IO_WR, 20'h00040, 8'h3C,
                                   z180_glue_pkg::REG_LED, 8'h00));
        stim_q.push_back(make_stim(z180_glue_pkg::OP_IO_RD, 20'h00040, 8'h00,
                                   z180_glue_pkg::REG_LED, 8'h3C));
        stim_q.push_back(make_stim(z180_glue_pkg::OP_IO_WR, 20'h0A540, 8'hC3,
                                   z180_glue_pkg::REG_LED, 8'h00));    // High byte not decoded
        stim_q.push_back(make_stim(z180_glue_pkg::OP_IO_RD, 20'h00041, 8'h00,
                                   z180_glue_pkg::REG_NONE, 8'h00));
        stim_q.push_back(make_stim(z180_glue_pkg::OP_IO_WR, 20'h00080, 8'h0F,
                                   z180_glue_pkg::REG_NONE, 8'h00));
        stim_q.push_back(make_stim(z180_glue_pkg::OP_INTA, 20'h00040, 8'h00,
                                   z180_glue_pkg::REG_NONE, 8'h00));   // INTA on the LED port
        stim_q.push_back(make_stim(z180_glue_pkg::OP_IO_RD, 20'h00040, 8'h00,
                                   z180_glue_pkg::REG_LED, 8'hC3));

        repeat (10) next_cycle();
        check_led(led, 8'hFF);
        check_level("reset_n", reset_n, 1'b0);
        check_level("d_oe", d_oe, 1'b0);
        check_sram_ctl(sram_pins(), SRAM_IDLE);
        check_tie_offs();
        rst = 1'b0;
        wait_reset_high("power-on release of reset_n");

        foreach (stim_q[i])
            run_access(stim_q[i]);

        // Random ROM reads
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $unsigned($random(seed));
            run_access(make_stim(z180_glue_pkg::OP_MEM_RD,
                                 z180_glue_pkg::addr_t'(rnd % ROM_BYTES), 8'h00,
                                 z180_glue_pkg::REG_ROM, 8'h00));
        end

        check_board();
        check_tie_offs();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verilog/addr_decode.sv ====
/*
 * Stage 2 of the bus pipeline
 *   Classifies each started access into ROM, SRAM, LED or no target
 *   and forwards the end strobe with the same one-cycle delay
 */
`timescale 1ns/1ps

module addr_decode #(
    parameter int         ROM_BYTES = z180_glue_pkg::ROM_BYTES_DEF,
    parameter logic [7:0] LED_PORT  = z180_glue_pkg::LED_PORT_DEF
) (
    input  logic                            hwclk,
    input  logic                            rst,
    input  logic                            start_stb,
    input  z180_glue_pkg::bus_access_t      start_acc,
    input  logic                            end_stb,
    output logic                            dec_stb,
    output z180_glue_pkg::decoded_access_t  dec_acc,
    output logic                            dec_end_stb
);

    z180_glue_pkg::region_e region;     // Target of the incoming access

    // Memory splits at the boot boundary, I/O decodes the low byte only
    always_comb begin
        case (start_acc.op)
            z180_glue_pkg::OP_MEM_RD, z180_glue_pkg::OP_MEM_WR:
                region = (start_acc.addr < z180_glue_pkg::addr_t'(ROM_BYTES)) ?
                         z180_glue_pkg::REG_ROM : z180_glue_pkg::REG_SRAM;
            z180_glue_pkg::OP_IO_RD, z180_glue_pkg::OP_IO_WR:
                region = (start_acc.addr[7:0] == LED_PORT) ?
                         z180_glue_pkg::REG_LED : z180_glue_pkg::REG_NONE;
            default:
                region = z180_glue_pkg::REG_NONE;   // INTA gets no answer
        endcase
    end

    // ******************************
    // Output registers
    // ******************************
    always_ff @(posedge hwclk) begin
        if (rst) begin
            dec_stb     <= 1'b0;
            dec_end_stb <= 1'b0;
        end else begin
            dec_stb     <= start_stb;
            dec_end_stb <= end_stb;     // Keeps start and end aligned
        end
    end

    always_ff @(posedge hwclk) begin
        if (start_stb)
            dec_acc <= '{op: start_acc.op, region: region,
                         addr: start_acc.addr, wdata: start_acc.wdata};
    end

endmodule

// ==== verilog/board_control.sv ====
/*
 * Board support
 *   CPU crystal clock at hwclk / 2
 *   Stretched CPU reset from the s1_n push button
 */
`timescale 1ns/1ps

module board_control #(
    parameter int RESET_HOLD = z180_glue_pkg::RESET_HOLD_DEF
) (
    input  logic hwclk,
    input  logic rst,
    input  logic s1_n,
    output logic extal,
    output logic reset_n
);

    localparam int CNT_W = $clog2(RESET_HOLD + 1);

    logic             extal_q;      // Divided clock
    logic             s1_meta;      // Button synchronizer
    logic             s1_sync;
    logic [CNT_W-1:0] hold_cnt;     // Cycles left before reset release
    logic             reset_n_q;

    // ******************************
    // CPU clock
    // ******************************
    always_ff @(posedge hwclk) begin
        if (rst)
            extal_q <= 1'b0;
        else
            extal_q <= ~extal_q;
    end

    // ******************************
    // CPU reset stretcher
    // ******************************
    always_ff @(posedge hwclk) begin
        if (rst) begin
            s1_meta   <= 1'b1;
            s1_sync   <= 1'b1;
            hold_cnt  <= CNT_W'(RESET_HOLD);    // Power-on reset is stretched too
            reset_n_q <= 1'b0;
        end else begin
            s1_meta <= s1_n;
            s1_sync <= s1_meta;
            if (!s1_sync) begin
                hold_cnt  <= CNT_W'(RESET_HOLD);    // Reload while pressed
                reset_n_q <= 1'b0;
            end else if (hold_cnt != '0) begin
                hold_cnt  <= hold_cnt - 1'b1;
                reset_n_q <= (hold_cnt == CNT_W'(1));  // Release on last count
            end else begin
                reset_n_q <= 1'b1;
            end
        end
    end

    assign extal   = extal_q;
    assign reset_n = reset_n_q;

endmodule

// ==== verilog/boot_rom.hex ====
// Boot ROM image with 16 bytes per line, one column per address
// Line n starts at address 16*n, upper half holds the inverted low address byte
00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D 1E 1F
20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F
30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D 3E 3F
40 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F
50 51 52 53 54 55 56 57 58 59 5A 5B 5C 5D 5E 5F
60 61 62 63 64 65 66 67 68 69 6A 6B 6C 6D 6E 6F
70 71 72 73 74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F
90 91 92 93 94 95 96 97 98 99 9A 9B 9C 9D 9E 9F
A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF
B0 B1 B2 B3 B4 B5 B6 B7 B8 B9 BA BB BC BD BE BF
C0 C1 C2 C3 C4 C5 C6 C7 C8 C9 CA CB CC CD CE CF
D0 D1 D2 D3 D4 D5 D6 D7 D8 D9 DA DB DC DD DE DF
E0 E1 E2 E3 E4 E5 E6 E7 E8 E9 EA EB EC ED EE EF
F0 F1 F2 F3 F4 F5 F6 F7 F8 F9 FA FB FC FD FE FF
FF FE FD FC FB FA F9 F8 F7 F6 F5 F4 F3 F2 F1 F0
EF EE ED EC EB EA E9 E8 E7 E6 E5 E4 E3 E2 E1 E0
DF DE DD DC DB DA D9 D8 D7 D6 D5 D4 D3 D2 D1 D0
CF CE CD CC CB CA C9 C8 C7 C6 C5 C4 C3 C2 C1 C0
BF BE BD BC BB BA B9 B8 B7 B6 B5 B4 B3 B2 B1 B0
AF AE AD AC AB AA A9 A8 A7 A6 A5 A4 A3 A2 A1 A0
9F 9E 9D 9C 9B 9A 99 98 97 96 95 94 93 92 91 90
8F 8E 8D 8C 8B 8A 89 88 87 86 85 84 83 82 81 80
7F 7E 7D 7C 7B 7A 79 78 77 76 75 74 73 72 71 70
6F 6E 6D 6C 6B 6A 69 68 67 66 65 64 63 62 61 60
5F 5E 5D 5C 5B 5A 59 58 57 56 55 54 53 52 51 50
4F 4E 4D 4C 4B 4A 49 48 47 46 45 44 43 42 41 40
3F 3E 3D 3C 3B 3A 39 38 37 36 35 34 33 32 31 30
2F 2E 2D 2C 2B 2A 29 28 27 26 25 24 23 22 21 20
1F 1E 1D 1C 1B 1A 19 18 17 16 15 14 13 12 11 10
0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00

// ==== verilog/boot_rom.sv ====
/*
 * Boot ROM, 512 bytes
 *   Synchronous read, contents loaded from the boot hex image
 */
`timescale 1ns/1ps

module boot_rom (
    input  logic                    hwclk,
    input  logic [8:0]              addr,
    output z180_glue_pkg::data_t    data
);

    // ******************************
    // ROM array
    // ******************************
    z180_glue_pkg::data_t mem [0:511];     // One byte per CPU address

    // Image path is relative to the simulation run directory
    initial begin
        $readmemh("verilog/boot_rom.hex", mem);
    end

    // Registered read, maps onto block RAM
    always_ff @(posedge hwclk) begin
        data <= mem[addr];
    end

endmodule

// ==== verilog/bus_responder.sv ====
/*
 * Stage 3 of the bus pipeline
 *   Holds the response for the duration of an access: ROM read data,
 *   SRAM chip strobes, and the LED register with its read-back
 *   Instantiates the boot ROM
 */
`timescale 1ns/1ps

module bus_responder #(
    parameter int ROM_BYTES = z180_glue_pkg::ROM_BYTES_DEF
) (
    input  logic                            hwclk,
    input  logic                            rst,
    input  logic                            dec_stb,
    input  z180_glue_pkg::decoded_access_t  dec_acc,
    input  logic                            dec_end_stb,
    output z180_glue_pkg::data_t            d_out,
    output logic                            d_oe,
    output logic                            ce_n,
    output logic                            oe_n,
    output logic                            we_n,
    output logic [7:0]                      led
);

    // Response held between start and end of an access
    typedef enum logic [2:0] {
        RESP_IDLE,          // Nothing driven
        RESP_ROM,           // Boot ROM byte on the data bus
        RESP_SRAM_RD,       // SRAM selected, output enabled
        RESP_SRAM_WR,       // SRAM selected, write enabled
        RESP_LED_RD         // LED register read back
    } resp_e;

    resp_e                  state;
    resp_e                  next_resp;  // Response for the access in dec_acc
    z180_glue_pkg::data_t   led_q;      // LED register, true polarity
    z180_glue_pkg::data_t   rom_data;
    logic                   led_wr;

    assign led_wr  = dec_stb && dec_acc.region == z180_glue_pkg::REG_LED &&
                     dec_acc.op == z180_glue_pkg::OP_IO_WR;

    // ******************************
    // Response selection
    // ******************************
    always_comb begin
        next_resp = RESP_IDLE;
        case (dec_acc.region)
            z180_glue_pkg::REG_ROM:
                if (dec_acc.op == z180_glue_pkg::OP_MEM_RD)
                    next_resp = RESP_ROM;   // ROM writes fall through to idle
            z180_glue_pkg::REG_SRAM:
                next_resp = (dec_acc.op == z180_glue_pkg::OP_MEM_WR) ?
                            RESP_SRAM_WR : RESP_SRAM_RD;
            z180_glue_pkg::REG_LED:
                if (dec_acc.op == z180_glue_pkg::OP_IO_RD)
                    next_resp = RESP_LED_RD;
            default:
                next_resp = RESP_IDLE;
        endcase
    end

    always_ff @(posedge hwclk) begin
        if (rst) begin
            state <= RESP_IDLE;
            led_q <= '0;
        end else begin
            if (dec_end_stb)
                state <= RESP_IDLE;         // Release one cycle after end
            else if (dec_stb)
                state <= next_resp;
            if (led_wr)
                led_q <= dec_acc.wdata;
        end
    end

    // Address held in dec_acc, so ROM data lines up with d_oe
    boot_rom u_rom (
        .hwclk  (hwclk),
        .addr   (dec_acc.addr[8:0]),
        .data   (rom_data)
    );

    // ******************************
    // Bus and SRAM outputs
    // ******************************
    assign d_oe  = (state == RESP_ROM) || (state == RESP_LED_RD);
    assign d_out = (state == RESP_ROM) ? rom_data : led_q;
    assign ce_n  = !((state == RESP_SRAM_RD) || (state == RESP_SRAM_WR));
    assign oe_n  = (state != RESP_SRAM_RD);
    assign we_n  = (state != RESP_SRAM_WR);
    assign led   = ~led_q;                  // LEDs are active low

endmodule

// ==== verilog/bus_sampler.sv ====
/*
 * Stage 1 of the bus pipeline
 *   Double-registers the asynchronous CPU bus pins, classifies the
 *   cycle and emits one start and one end strobe per access
 */
`timescale 1ns/1ps

module bus_sampler (
    input  logic                        hwclk,
    input  logic                        rst,
    input  z180_glue_pkg::addr_t        a,
    input  z180_glue_pkg::data_t        d_in,
    input  logic                        mreq_n,
    input  logic                        iorq_n,
    input  logic                        rd_n,
    input  logic                        wr_n,
    input  logic                        m1_n,
    output logic                        start_stb,
    output z180_glue_pkg::bus_access_t  start_acc,
    output logic                        end_stb
);

    // CPU control strobes sampled as one group
    typedef struct packed {
        logic mreq_n;
        logic iorq_n;
        logic rd_n;
        logic wr_n;
        logic m1_n;
    } cpu_ctl_t;

    localparam cpu_ctl_t CTL_IDLE = '1;     // All strobes inactive

    cpu_ctl_t                   ctl_s1, ctl_s2;     // Synchronizer stages
    z180_glue_pkg::addr_t       addr_s1, addr_s2;
    z180_glue_pkg::data_t       data_s1, data_s2;
    z180_glue_pkg::access_op_e  op_s2;              // Cycle kind from stage 2
    logic                       act_s2;             // Access active in stage 2
    logic                       open_q;             // An access has been started

    // ******************************
    // Pin synchronizers
    // ******************************
    always_ff @(posedge hwclk) begin
        if (rst) begin
            ctl_s1 <= CTL_IDLE;
            ctl_s2 <= CTL_IDLE;
        end else begin
            ctl_s1 <= {mreq_n, iorq_n, rd_n, wr_n, m1_n};
            ctl_s2 <= ctl_s1;
        end
    end

    // Address and data follow the strobes, no reset needed
    always_ff @(posedge hwclk) begin
        addr_s1 <= a;
        addr_s2 <= addr_s1;
        data_s1 <= d_in;
        data_s2 <= data_s1;
    end

    // INTA checked first, M1 with IORQ is never a plain I/O cycle
    always_comb begin
        act_s2 = 1'b1;
        op_s2  = z180_glue_pkg::OP_MEM_RD;
        if (!ctl_s2.iorq_n && !ctl_s2.m1_n)
            op_s2 = z180_glue_pkg::OP_INTA;
        else if (!ctl_s2.mreq_n && !ctl_s2.rd_n)
            op_s2 = z180_glue_pkg::OP_MEM_RD;
        else if (!ctl_s2.mreq_n && !ctl_s2.wr_n)
            op_s2 = z180_glue_pkg::OP_MEM_WR;
        else if (!ctl_s2.iorq_n && !ctl_s2.rd_n)
            op_s2 = z180_glue_pkg::OP_IO_RD;
        else if (!ctl_s2.iorq_n && !ctl_s2.wr_n)
            op_s2 = z180_glue_pkg::OP_IO_WR;
        else
            act_s2 = 1'b0;                  // Bus idle
    end

    // ******************************
    // Start and end strobes
    // ******************************
    always_ff @(posedge hwclk) begin
        if (rst) begin
            open_q    <= 1'b0;
            start_stb <= 1'b0;
            end_stb   <= 1'b0;
        end else begin
            start_stb <= act_s2 && !open_q;     // Rising edge of activity
            end_stb   <= !act_s2 && open_q;     // Return to idle
            open_q    <= act_s2;
        end
    end

    always_ff @(posedge hwclk) begin
        if (act_s2 && !open_q)
            start_acc <= '{op: op_s2, addr: addr_s2, wdata: data_s2};
    end

endmodule

// ==== verilog/z180_glue_pkg.sv ====
/*
 * Shared types for the Z180 board glue logic
 *   addr_t, data_t            CPU address and data words
 *   access_op_e, region_e     bus cycle kind and access target
 *   bus_access_t              access captured by the bus sampler
 *   decoded_access_t          access after address decode
 */
package z180_glue_pkg;

    // ******************************
    // Basic bus words
    // ******************************
    typedef logic [19:0] addr_t;        // 1 MB physical address space
    typedef logic [7:0]  data_t;        // 8-bit data bus

    // Kind of bus cycle seen on the CPU strobes
    typedef enum logic [2:0] {
        OP_MEM_RD,                      // MREQ + RD
        OP_MEM_WR,                      // MREQ + WR
        OP_IO_RD,                       // IORQ + RD
        OP_IO_WR,                       // IORQ + WR
        OP_INTA                         // IORQ + M1, interrupt acknowledge
    } access_op_e;

    // Target of a decoded access
    typedef enum logic [1:0] {
        REG_ROM,                        // On-chip boot ROM
        REG_SRAM,                       // External static RAM
        REG_LED,                        // LED register port
        REG_NONE                        // Unmapped, no response
    } region_e;

    // ******************************
    // Pipeline payloads
    // ******************************
    typedef struct packed {
        access_op_e op;
        addr_t      addr;
        data_t      wdata;              // Only meaningful for writes
    } bus_access_t;

    typedef struct packed {
        access_op_e op;
        region_e    region;
        addr_t      addr;
        data_t      wdata;
    } decoded_access_t;

    // Default settings, overridden from the top level
    localparam int          ROM_BYTES_DEF  = 512;   // ROM/SRAM boundary
    localparam logic [7:0]  LED_PORT_DEF   = 8'h40; // Low address byte only
    localparam int          RESET_HOLD_DEF = 16;    // hwclk cycles after s1_n release

endpackage

// ==== verilog/z180_glue_top.sv ====
/*
 * Top level of the Z180 board glue logic
 *   Bus sampler, address decode and responder pipeline,
 *   board clock and reset, tie-offs for unused CPU inputs
 */
`timescale 1ns/1ps

module z180_glue_top #(
    parameter int         ROM_BYTES  = z180_glue_pkg::ROM_BYTES_DEF,
    parameter logic [7:0] LED_PORT   = z180_glue_pkg::LED_PORT_DEF,
    parameter int         RESET_HOLD = z180_glue_pkg::RESET_HOLD_DEF
) (
    input  logic                    hwclk,
    input  logic                    rst,
    input  logic                    s1_n,
    // CPU bus
    input  z180_glue_pkg::addr_t    a,
    input  logic                    mreq_n,
    input  logic                    iorq_n,
    input  logic                    rd_n,
    input  logic                    wr_n,
    input  logic                    m1_n,
    input  z180_glue_pkg::data_t    d_in,
    output z180_glue_pkg::data_t    d_out,
    output logic                    d_oe,       // Pad tristate lives in the board wrapper
    // SRAM and LEDs
    output logic                    ce_n,
    output logic                    oe_n,
    output logic                    we_n,
    output logic [7:0]              led,
    // CPU control
    output logic                    extal,
    output logic                    reset_n,
    output logic                    busreq_n,
    output logic                    dreq1_n,
    output logic [2:0]              int_n,
    output logic                    nmi_n,
    output logic                    wait_n
);

    logic                           start_stb, end_stb;
    z180_glue_pkg::bus_access_t     start_acc;
    logic                           dec_stb, dec_end_stb;
    z180_glue_pkg::decoded_access_t dec_acc;

    // ******************************
    // Bus pipeline
    // ******************************
    bus_sampler u_sampler (
        .hwclk, .rst, .a, .d_in, .mreq_n, .iorq_n, .rd_n, .wr_n, .m1_n,
        .start_stb, .start_acc, .end_stb
    );

    addr_decode #(.ROM_BYTES(ROM_BYTES), .LED_PORT(LED_PORT)) u_decode (
        .hwclk, .rst, .start_stb, .start_acc, .end_stb,
        .dec_stb, .dec_acc, .dec_end_stb
    );

    bus_responder #(.ROM_BYTES(ROM_BYTES)) u_responder (
        .hwclk, .rst, .dec_stb, .dec_acc, .dec_end_stb,
        .d_out, .d_oe, .ce_n, .oe_n, .we_n, .led
    );

    board_control #(.RESET_HOLD(RESET_HOLD)) u_board (
        .hwclk, .rst, .s1_n, .extal, .reset_n
    );

    // Unused CPU requests held inactive
    assign busreq_n = 1'b1;
    assign dreq1_n  = 1'b1;
    assign int_n    = 3'b111;       // INT0 to INT2
    assign nmi_n    = 1'b1;
    assign wait_n   = 1'b1;         // No wait states

endmodule
